//--- bench/dcache_asserts.sv
module dcache_asserts import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input cpu_req_t cpu_req,
	input cpu_rsp_t cpu_rsp,
	input mem_req_t mem_req,
	input logic dwait
);

	int fail_count = 0; // failed assertions so far

	// one direction on the memory port at a time
	one_direction: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.read && mem_req.write))
	else begin
		$error("memory read and write high together");
		fail_count++;
	end

	hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_req.read || mem_req.write) && dwait |=> $stable(mem_req))
	else begin
		$error("memory request changed while dwait was high");
		fail_count++;
	end

	flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		cpu_rsp.flushed |=> cpu_rsp.flushed)
	else begin
		$error("flushed fell before reset");
		fail_count++;
	end

	// no CPU answers during the flush walk
	quiet_flush: assert property (@(posedge CLK) disable iff (!nRST)
		cpu_req.halt && !cpu_rsp.flushed |-> !cpu_rsp.dhit)
	else begin
		$error("dhit high while flushing");
		fail_count++;
	end

endmodule

bind dcache dcache_asserts asserts_inst (
	.CLK(CLK),
	.nRST(nRST),
	.cpu_req(cpu_req),
	.cpu_rsp(cpu_rsp),
	.mem_req(mem_req),
	.dwait(dwait)
);

//--- bench/dcache_tb.sv
module dcache_tb import dcache_pkg::*; ();

	localparam int NUM_OPS = 300;
	localparam int PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int MISS_BOUND = 80; // in cycles for dwait runs of up to 16
	localparam int WATCHDOG = (RESET_CYCLES + (NUM_OPS + 16) * MISS_BOUND) * PERIOD;

	typedef struct packed {
		logic wr;
		word_t addr;
		word_t data;
	} xfer_t;

	logic CLK;
	logic nRST;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	mem_req_t mem_req;
	logic dwait = 1'b0;
	word_t mem_load;

	word_t mem [64];     // memory behind the DUT
	word_t ref_mem [64]; // last value the bench wrote
	xfer_t xfers [$];    // memory transfers of the current op

	// cache and link model
	logic [1:0] m_tag [NUM_SETS][NUM_WAYS];
	logic m_valid [NUM_SETS][NUM_WAYS];
	logic m_dirty [NUM_SETS][NUM_WAYS];
	logic m_used [NUM_SETS];
	logic link_v;
	word_t link_a;

	logic [15:0] op_lfsr = 16'd46;
	logic [15:0] wait_lfsr = 16'd46;
	int errors;
	int ops;

	dcache dcache_inst (
		.CLK(CLK),
		.nRST(nRST),
		.cpu_req(cpu_req),
		.dwait(dwait),
		.mem_load(mem_load),
		.cpu_rsp(cpu_rsp),
		.mem_req(mem_req)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			op_lfsr = lfsr_next(op_lfsr);
			v = {v[30:0], op_lfsr[0]};
		end
		return v;
	endfunction

	function automatic word_t fill_word(word_t a);
		return (a ^ 32'h5a5a_0000) * 32'h9e37_79b1;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	task automatic print_summary();
		$display("summary: %0d ops, %0d bench errors, %0d assertion failures",
			ops, errors, dcache_inst.asserts_inst.fail_count);
	endtask

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	assign mem_load = mem[mem_req.addr[7:2]];

	// memory model takes one word per completed transfer
	always @(posedge CLK) begin
		wait_lfsr = lfsr_next(wait_lfsr);
		if (!nRST) begin
			for (int i = 0; i < 64; i++) begin
				mem[i] <= fill_word({24'h0, i[5:0], 2'b00});
			end
		end else if (!dwait) begin
			if (mem_req.write) begin
				mem[mem_req.addr[7:2]] <= mem_req.store;
				xfers.push_back({1'b1, mem_req.addr, mem_req.store});
			end else if (mem_req.read) begin
				xfers.push_back({1'b0, mem_req.addr, mem_load});
			end
		end
		dwait <= wait_lfsr[0];
	end

	task automatic run_op(input logic rd, input logic wr, input logic at, input word_t addr,
			input word_t data);
		set_idx_t s;
		logic [5:0] idx;
		logic way;
		logic hit_m;
		logic sc_fail;
		word_t wa;
		word_t exp_load;
		int cycles;
		xfer_t exp_q [$];
		s = addr[5:3];
		idx = addr[7:2];
		hit_m = 1'b0;
		way = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == addr[7:6]) begin
				hit_m = 1'b1;
				way = w[0];
			end
		end
		sc_fail = wr && at && !(link_v && link_a == addr);
		if (!hit_m && !sc_fail) begin
			if (!m_valid[s][0]) begin
				way = 1'b0;
			end else if (!m_valid[s][1]) begin
				way = 1'b1;
			end else begin
				way = ~m_used[s];
			end
			if (m_valid[s][way] && m_dirty[s][way]) begin
				for (int b = 0; b < 2; b++) begin
					wa = {24'h0, m_tag[s][way], s, b[0], 2'b00};
					exp_q.push_back({1'b1, wa, ref_mem[wa[7:2]]});
				end
			end
			for (int b = 0; b < 2; b++) begin
				wa = {addr[31:3], b[0], 2'b00};
				exp_q.push_back({1'b0, wa, ref_mem[wa[7:2]]});
			end
		end

		xfers.delete();
		cpu_req <= '{rd, wr, at, 1'b0, addr, data};
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
		end while (!cpu_rsp.dhit);

		exp_load = sc_fail ? 32'd0 : (at && wr) ? 32'd1 : ref_mem[idx];
		if (rd || at) begin
			assert (cpu_rsp.load == exp_load)
			else report_error($sformatf("load at 0x%h gave 0x%h, expected 0x%h",
				addr, cpu_rsp.load, exp_load));
		end
		if (hit_m || sc_fail) begin
			assert (cycles == 1)
			else report_error($sformatf("hit at 0x%h took %0d cycles", addr, cycles));
		end
		assert (xfers.size() == exp_q.size())
		else report_error($sformatf("access 0x%h made %0d memory transfers, expected %0d",
			addr, xfers.size(), exp_q.size()));
		for (int i = 0; i < exp_q.size() && i < xfers.size(); i++) begin
			assert (xfers[i] == exp_q[i])
			else report_error($sformatf("transfer %0d for 0x%h is %b/0x%h/0x%h, expected %b/0x%h/0x%h",
				i, addr, xfers[i].wr, xfers[i].addr, xfers[i].data,
				exp_q[i].wr, exp_q[i].addr, exp_q[i].data));
		end

		// model update
		if (!sc_fail) begin
			if (!hit_m) begin
				m_tag[s][way] = addr[7:6];
				m_valid[s][way] = 1'b1;
				m_dirty[s][way] = 1'b0;
			end
			m_used[s] = way;
			if (wr) begin
				m_dirty[s][way] = 1'b1;
				ref_mem[idx] = data;
				if (link_v && link_a == addr) begin
					link_v = 1'b0;
				end
			end else if (at) begin
				link_v = 1'b1;
				link_a = addr;
			end
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic [2:0] kind;
		word_t a;
		word_t d;
		word_t last_ll;
		cpu_req_t req;
		cpu_req = '0;
		nRST = 1'b0;
		errors = 0;
		ops = 0;
		link_v = 1'b0;
		link_a = '0;
		last_ll = '0;
		for (int s = 0; s < NUM_SETS; s++) begin
			m_used[s] = 1'b0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		for (int i = 0; i < 64; i++) begin
			ref_mem[i] = fill_word({24'h0, i[5:0], 2'b00});
		end
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		@(posedge CLK);

		for (int n = 0; n < NUM_OPS; n++) begin
			rnd = take_bits(3);
			kind = rnd[2:0];
			rnd = take_bits(6); // 4 tags over all sets and words
			a = {24'h0, rnd[5:0], 2'b00};
			d = take_bits(32);
			if (kind == 3'd7 && take_bits(1) == 32'd1) begin
				a = last_ll; // aim the SC at the last link
			end
			case (kind)
				3'd0, 3'd1, 3'd2: run_op(1'b1, 1'b0, 1'b0, a, d);
				3'd3, 3'd4, 3'd5: run_op(1'b0, 1'b1, 1'b0, a, d);
				3'd6: begin
					run_op(1'b1, 1'b0, 1'b1, a, d);
					last_ll = a;
				end
				default: run_op(1'b0, 1'b1, 1'b1, a, d);
			endcase
			ops++;
			rnd = take_bits(2);
			if (rnd[1:0] == 2'b00) begin
				cpu_req <= '0; // idle gap
				@(posedge CLK);
			end
		end

		rnd = take_bits(6);
		a = {24'h0, rnd[5:0], 2'b00};
		d = take_bits(32);
		req = '0;
		req.halt = 1'b1;
		req.write = 1'b1; // store left pending under halt, never answered
		req.addr = a;
		req.store = d;
		cpu_req <= req;
		do begin
			@(posedge CLK);
		end while (!cpu_rsp.flushed);
		repeat (8) begin
			@(posedge CLK);
			assert (cpu_rsp.flushed)
			else report_error("flushed fell after the flush");
		end
		for (int i = 0; i < 64; i++) begin
			assert (mem[i] == ref_mem[i])
			else report_error($sformatf("memory word 0x%h is 0x%h after flush, expected 0x%h",
				i * 4, mem[i], ref_mem[i]));
		end

		print_summary();
		if (errors == 0 && dcache_inst.asserts_inst.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG);
		$display("timeout: the cache did not finish the test sequence in time");
		print_summary();
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
logic/dcache_pkg.sv
logic/dcache_frame_store.sv
logic/dcache_controller.sv
logic/dcache_link_reg.sv
logic/dcache.sv
bench/dcache_asserts.sv
bench/dcache_tb.sv

//--- logic/dcache.sv
module dcache import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input cpu_req_t cpu_req,
	input logic dwait,
	input word_t mem_load,
	output cpu_rsp_t cpu_rsp,
	output mem_req_t mem_req
);

	// lookup results
	logic hit, hit_way, victim_way;
	word_t hit_word;
	frame_t view_frame;

	// controller to storage
	set_idx_t view_set;
	logic view_way;
	frame_cmd_t cmd;

	// link register
	logic link_set, store_seen, link_ok;

	dcache_frame_store frame_store_inst (
		.CLK(CLK),
		.nRST(nRST),
		.lookup_addr(cpu_req.addr),
		.view_set(view_set),
		.view_way(view_way),
		.cmd(cmd),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.view_frame(view_frame),
		.hit_word(hit_word)
	);

	dcache_controller controller_inst (
		.CLK(CLK),
		.nRST(nRST),
		.cpu_req(cpu_req),
		.dwait(dwait),
		.mem_load(mem_load),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.view_frame(view_frame),
		.hit_word(hit_word),
		.link_ok(link_ok),
		.cpu_rsp(cpu_rsp),
		.mem_req(mem_req),
		.view_set(view_set),
		.view_way(view_way),
		.cmd(cmd),
		.link_set(link_set),
		.store_seen(store_seen)
	);

	dcache_link_reg link_reg_inst (
		.CLK(CLK),
		.nRST(nRST),
		.addr(cpu_req.addr),
		.link_set(link_set),
		.store_seen(store_seen),
		.link_ok(link_ok)
	);

endmodule

//--- logic/dcache_controller.sv
module dcache_controller import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input cpu_req_t cpu_req,
	input logic dwait,
	input word_t mem_load,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input frame_t view_frame,
	input word_t hit_word,
	input logic link_ok,
	output cpu_rsp_t cpu_rsp,
	output mem_req_t mem_req,
	output set_idx_t view_set,
	output logic view_way,
	output frame_cmd_t cmd,
	output logic link_set,
	output logic store_seen
);

	ctrl_state_t state, state_n;
	logic miss_way, miss_way_n;        // victim latched at the start of a miss
	frame_sel_t flush_sel, flush_sel_n;

	tag_t req_tag;
	set_idx_t req_set;
	logic req_word;
	logic access;
	logic last_frame;
	logic view_dirty;

	assign req_tag = addr_tag(cpu_req.addr);
	assign req_set = addr_set(cpu_req.addr);
	assign req_word = addr_word(cpu_req.addr);
	assign access = cpu_req.read | cpu_req.write;
	assign last_frame = (flush_sel == frame_sel_t'(NUM_SETS * NUM_WAYS - 1));
	assign view_dirty = view_frame.valid & view_frame.dirty;

	// which frame the store shows us
	always_comb begin
		case (state)
			FLUSH_WORD0, FLUSH_WORD1, FLUSH_NEXT: begin
				view_set = flush_sel[2:0];
				view_way = flush_sel[3];
			end
			IDLE: begin
				view_set = req_set;
				view_way = victim_way; // dirty check before a miss starts
			end
			default: begin
				view_set = req_set;
				view_way = miss_way;
			end
		endcase
	end

	always_comb begin
		state_n = state;
		miss_way_n = miss_way;
		flush_sel_n = flush_sel;

		cpu_rsp = '0;
		cpu_rsp.flushed = (state == FLUSHED);
		mem_req = '0;
		link_set = 1'b0;
		store_seen = 1'b0;

		cmd = '0;
		cmd.idx = req_set;
		cmd.way = miss_way;
		cmd.word = req_word;
		cmd.tag = req_tag;
		cmd.data = cpu_req.store;

		case (state)
			IDLE: begin
				if (cpu_req.halt) begin
					state_n = FLUSH_WORD0;
					flush_sel_n = '0;
				end else if (cpu_req.write && cpu_req.atomic && !link_ok) begin
					cpu_rsp.dhit = 1'b1; // failed SC, nothing stored
				end else if (access && hit) begin
					cpu_rsp.dhit = 1'b1;
					cmd.way = hit_way;
					cmd.touch = 1'b1;
					if (cpu_req.write) begin
						cmd.write_word = 1'b1;
						cmd.set_dirty = 1'b1;
						store_seen = 1'b1;
						cpu_rsp.load = word_t'(cpu_req.atomic); // SC success returns 1
					end else begin
						cpu_rsp.load = hit_word;
						link_set = cpu_req.atomic;
					end
				end else if (access) begin
					miss_way_n = victim_way;
					state_n = view_dirty ? WB_WORD0 : FETCH_WORD0;
				end
			end

			// victim writeback
			WB_WORD0: begin
				mem_req.write = 1'b1;
				mem_req.addr = block_addr(view_frame.tag, req_set, 1'b0);
				mem_req.store = view_frame.data[0];
				if (!dwait) begin
					state_n = WB_WORD1;
				end
			end
			WB_WORD1: begin
				mem_req.write = 1'b1;
				mem_req.addr = block_addr(view_frame.tag, req_set, 1'b1);
				mem_req.store = view_frame.data[1];
				if (!dwait) begin
					cmd.clr_dirty = 1'b1;
					state_n = FETCH_WORD0;
				end
			end

			// block fetch into the latched way
			FETCH_WORD0: begin
				mem_req.read = 1'b1;
				mem_req.addr = block_addr(req_tag, req_set, 1'b0);
				if (!dwait) begin
					cmd.fill = 1'b1;
					cmd.word = 1'b0;
					cmd.data = mem_load;
					state_n = FETCH_WORD1;
				end
			end
			FETCH_WORD1: begin
				mem_req.read = 1'b1;
				mem_req.addr = block_addr(req_tag, req_set, 1'b1);
				if (!dwait) begin
					cmd.fill = 1'b1;
					cmd.word = 1'b1;
					cmd.data = mem_load;
					state_n = FETCH_DONE;
				end
			end
			FETCH_DONE: begin
				cpu_rsp.dhit = 1'b1;
				cmd.touch = 1'b1;
				if (cpu_req.write) begin
					cmd.write_word = 1'b1;
					cmd.set_dirty = 1'b1;
					store_seen = 1'b1;
					cpu_rsp.load = word_t'(cpu_req.atomic & link_ok);
				end else begin
					cpu_rsp.load = view_frame.data[req_word];
					link_set = cpu_req.atomic;
				end
				state_n = IDLE;
			end

			// walk all frames on halt; clean ones take a single cycle
			FLUSH_WORD0: begin
				cmd.idx = flush_sel[2:0];
				cmd.way = flush_sel[3];
				if (view_dirty) begin
					mem_req.write = 1'b1;
					mem_req.addr = block_addr(view_frame.tag, flush_sel[2:0], 1'b0);
					mem_req.store = view_frame.data[0];
					if (!dwait) begin
						state_n = FLUSH_WORD1;
					end
				end else if (last_frame) begin
					state_n = FLUSHED;
				end else begin
					flush_sel_n = flush_sel + 1'b1;
				end
			end
			FLUSH_WORD1: begin
				cmd.idx = flush_sel[2:0];
				cmd.way = flush_sel[3];
				mem_req.write = 1'b1;
				mem_req.addr = block_addr(view_frame.tag, flush_sel[2:0], 1'b1);
				mem_req.store = view_frame.data[1];
				if (!dwait) begin
					cmd.clr_dirty = 1'b1;
					state_n = FLUSH_NEXT;
				end
			end
			FLUSH_NEXT: begin
				if (last_frame) begin
					state_n = FLUSHED;
				end else begin
					flush_sel_n = flush_sel + 1'b1;
					state_n = FLUSH_WORD0;
				end
			end
			FLUSHED: begin
				state_n = FLUSHED; // held until reset
			end
			default: begin
				state_n = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			miss_way <= 1'b0;
			flush_sel <= '0;
		end else begin
			state <= state_n;
			miss_way <= miss_way_n;
			flush_sel <= flush_sel_n;
		end
	end

endmodule

//--- logic/dcache_frame_store.sv
module dcache_frame_store import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input word_t lookup_addr,
	input set_idx_t view_set,
	input logic view_way,
	input frame_cmd_t cmd,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output frame_t view_frame,
	output word_t hit_word
);

	// payload storage
	tag_t tag_mem [NUM_SETS][NUM_WAYS];
	word_t [WORDS_PER_BLOCK-1:0] data_mem [NUM_SETS][NUM_WAYS];

	// per-frame control bits
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
	logic [NUM_SETS-1:0] used_q; // way touched last in each set

	tag_t lk_tag;
	set_idx_t lk_set;
	logic lk_word;
	logic [NUM_WAYS-1:0] match;

	assign lk_tag = addr_tag(lookup_addr);
	assign lk_set = addr_set(lookup_addr);
	assign lk_word = addr_word(lookup_addr);

	// tag compare on both ways of the set
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			match[w] = valid_q[lk_set][w] && (tag_mem[lk_set][w] == lk_tag);
		end
	end

	assign hit = |match;
	assign hit_way = match[1];
	assign hit_word = data_mem[lk_set][hit_way][lk_word];

	// empty way first, otherwise the one not used last
	always_comb begin
		if (!valid_q[lk_set][0]) begin
			victim_way = 1'b0;
		end else if (!valid_q[lk_set][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = ~used_q[lk_set];
		end
	end

	// frame seen by the controller for writeback, flush and miss return
	always_comb begin
		view_frame.tag = tag_mem[view_set][view_way];
		view_frame.valid = valid_q[view_set][view_way];
		view_frame.dirty = dirty_q[view_set][view_way];
		view_frame.data = data_mem[view_set][view_way];
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
			used_q <= '0;
		end else begin
			if (cmd.fill) begin
				valid_q[cmd.idx][cmd.way] <= 1'b1;
				dirty_q[cmd.idx][cmd.way] <= 1'b0; // fresh block from memory
			end
			if (cmd.clr_dirty) begin
				dirty_q[cmd.idx][cmd.way] <= 1'b0;
			end
			// a store wins over any clear in the same cycle
			if (cmd.set_dirty) begin
				dirty_q[cmd.idx][cmd.way] <= 1'b1;
			end
			if (cmd.touch) begin
				used_q[cmd.idx] <= cmd.way;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (cmd.fill) begin
			tag_mem[cmd.idx][cmd.way] <= cmd.tag;
		end
		if (cmd.fill || cmd.write_word) begin
			data_mem[cmd.idx][cmd.way][cmd.word] <= cmd.data;
		end
	end

endmodule

//--- logic/dcache_link_reg.sv
module dcache_link_reg import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input word_t addr,
	input logic link_set,   // load-link completes
	input logic store_seen, // any store completes
	output logic link_ok
);

	word_t link_addr;
	logic link_valid;
	logic addr_match;

	assign addr_match = (link_addr == addr);
	assign link_ok = link_valid & addr_match;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			link_valid <= 1'b0;
		end else if (link_set) begin
			link_valid <= 1'b1;
		end else if (store_seen && addr_match) begin
			link_valid <= 1'b0; // store to linked word breaks the link
		end
	end

	always_ff @(posedge CLK) begin
		if (link_set) begin
			link_addr <= addr;
		end
	end

endmodule

//--- logic/dcache_pkg.sv
package dcache_pkg;

	// cache geometry
	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 2;
	localparam int WORDS_PER_BLOCK = 2;

	typedef logic [31:0] word_t;
	typedef logic [25:0] tag_t;     // addr[31:6]
	typedef logic [2:0] set_idx_t;  // addr[5:3]
	typedef logic [3:0] frame_sel_t; // {way, set} while flushing

	typedef struct packed {
		tag_t tag;
		logic valid;
		logic dirty;
		word_t [WORDS_PER_BLOCK-1:0] data;
	} frame_t;

	typedef struct packed {
		logic read;
		logic write;
		logic atomic; // LL with read, SC with write
		logic halt;
		word_t addr;
		word_t store;
	} cpu_req_t;

	typedef struct packed {
		logic dhit;
		word_t load;
		logic flushed;
	} cpu_rsp_t;

	typedef struct packed {
		logic read;
		logic write;
		word_t addr;
		word_t store;
	} mem_req_t;

	// one update of the frame store, applied at the next edge
	typedef struct packed {
		logic write_word;
		logic fill;      // data word from memory, also sets tag and valid
		logic set_dirty;
		logic clr_dirty;
		logic touch;     // mark way as recently used
		set_idx_t idx;
		logic way;
		logic word;
		tag_t tag;
		word_t data;
	} frame_cmd_t;

	typedef enum logic [3:0] {
		IDLE, WB_WORD0, WB_WORD1, FETCH_WORD0, FETCH_WORD1, FETCH_DONE,
		FLUSH_WORD0, FLUSH_WORD1, FLUSH_NEXT, FLUSHED
	} ctrl_state_t;

	function automatic tag_t addr_tag(word_t a);
		return a[31:6];
	endfunction

	function automatic set_idx_t addr_set(word_t a);
		return a[5:3];
	endfunction

	function automatic logic addr_word(word_t a);
		return a[2];
	endfunction

	// byte address of one word in a block
	function automatic word_t block_addr(tag_t t, set_idx_t s, logic w);
		return {t, s, w, 2'b00};
	endfunction

endpackage
